//--- logic/pipe_pkg.sv
// Shared types for the five-stage RV32I subset pipeline
package pipe_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_IMM
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_op_e;

    // Instruction cache request, one-cycle strobe
    typedef struct packed {
        logic  valid;
        xlen_t addr;
    } icache_req_t;

    // Instruction cache response, one-cycle strobe
    typedef struct packed {
        logic  valid;
        xlen_t instr;
    } icache_resp_t;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t instr;
    } if_id_t;

    // Decoded instruction
    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        xlen_t      imm;
        logic       use_imm;
        alu_op_e    alu_op;
        branch_op_e branch_op;
        logic       we;
    } id_rr_t;

    // Decoded instruction with its register operands
    typedef struct packed {
        id_rr_t instr;
        xlen_t  data_rs1;
        xlen_t  data_rs2;
    } rr_exe_t;

    // Execute result, also the retired instruction on the commit port
    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        logic     we;
        reg_idx_t rd;
        xlen_t    data;
    } commit_t;

    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

endpackage

//--- logic/fetch_stage.sv
// Fetch stage: PC, instruction cache requests and discard of stale responses
`timescale 1ns/1ps

module fetch_stage #(
    parameter pipe_pkg::xlen_t RESET_PC = '0
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  pipe_pkg::icache_resp_t icache_resp_i,
    input  pipe_pkg::redirect_t    redirect_i,
    output pipe_pkg::icache_req_t  icache_req_o,
    output pipe_pkg::if_id_t       fetch_o
);
    import pipe_pkg::*;

    // Address of the request in flight or about to go out
    xlen_t pc_q;
    xlen_t pc_d;
    logic  req_q;
    logic  req_d;
    // Waiting for a response, not counting the request cycle itself
    logic  pending_q;
    logic  pending_d;
    // Outstanding request belongs to a flushed path
    logic  stale_q;
    logic  stale_d;
    logic  resp_fire;
    logic  resp_keep;
    logic  outstanding;

    assign resp_fire   = pending_q && icache_resp_i.valid;
    assign resp_keep   = resp_fire && !stale_q;
    assign outstanding = req_q || (pending_q && !resp_fire);

    always_comb begin
        // Idle after reset, or the previous fetch just finished
        req_d     = (!pending_q && !req_q) || resp_fire;
        pending_d = req_q || (pending_q && !resp_fire);

        stale_d = stale_q;
        if (resp_fire) begin
            stale_d = 1'b0;
        end
        if (redirect_i.valid && outstanding) begin
            stale_d = 1'b1;
        end

        pc_d = pc_q;
        if (resp_keep) begin
            pc_d = pc_q + 32'd4;
        end
        // Redirect wins over sequential fetch
        if (redirect_i.valid) begin
            pc_d = redirect_i.target;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q      <= RESET_PC;
            req_q     <= 1'b0;
            pending_q <= 1'b0;
            stale_q   <= 1'b0;
        end else begin
            pc_q      <= pc_d;
            req_q     <= req_d;
            pending_q <= pending_d;
            stale_q   <= stale_d;
        end
    end

    assign icache_req_o.valid = req_q;
    assign icache_req_o.addr  = pc_q;

    assign fetch_o.valid = resp_keep;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = icache_resp_i.instr;

endmodule

//--- logic/decoder.sv
// Instruction decoder for the supported RV32I subset
`timescale 1ns/1ps

module decoder (
    input  pipe_pkg::if_id_t fetch_i,
    output pipe_pkg::id_rr_t decode_o
);
    import pipe_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    xlen_t       imm_i;
    xlen_t       imm_u;
    xlen_t       imm_b;
    xlen_t       word;

    assign word   = fetch_i.instr;
    assign opcode = opcode_e'(word[6:0]);
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];

    // Sign-extended immediate formats
    assign imm_i = {{20{word[31]}}, word[31:20]};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};

    always_comb begin
        // Default is a no-op that still retires
        decode_o           = '0;
        decode_o.valid     = fetch_i.valid;
        decode_o.pc        = fetch_i.pc;
        decode_o.alu_op    = ALU_ADD;
        decode_o.branch_op = BR_NONE;

        case (opcode)
            OPC_OP: begin
                decode_o.rd  = word[11:7];
                decode_o.rs1 = word[19:15];
                decode_o.rs2 = word[24:20];
                decode_o.we  = 1'b1;
                if (funct7 == 7'b0000000 && funct3 == 3'b000) begin
                    decode_o.alu_op = ALU_ADD;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    decode_o.alu_op = ALU_SUB;
                end else if (funct7 == 7'b0000000 && funct3 == 3'b100) begin
                    decode_o.alu_op = ALU_XOR;
                end else if (funct7 == 7'b0000000 && funct3 == 3'b110) begin
                    decode_o.alu_op = ALU_OR;
                end else if (funct7 == 7'b0000000 && funct3 == 3'b111) begin
                    decode_o.alu_op = ALU_AND;
                end else begin
                    // Not in the subset
                    decode_o.rd  = '0;
                    decode_o.rs1 = '0;
                    decode_o.rs2 = '0;
                    decode_o.we  = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                // Only ADDI
                if (funct3 == 3'b000) begin
                    decode_o.rd      = word[11:7];
                    decode_o.rs1     = word[19:15];
                    decode_o.imm     = imm_i;
                    decode_o.use_imm = 1'b1;
                    decode_o.we      = 1'b1;
                end
            end
            OPC_LUI: begin
                decode_o.rd      = word[11:7];
                decode_o.imm     = imm_u;
                decode_o.use_imm = 1'b1;
                decode_o.alu_op  = ALU_PASS_IMM;
                decode_o.we      = 1'b1;
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    decode_o.rs1       = word[19:15];
                    decode_o.rs2       = word[24:20];
                    decode_o.imm       = imm_b;
                    decode_o.branch_op = (funct3 == 3'b000) ? BR_EQ : BR_NE;
                end
            end
            default: begin
                decode_o.we = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/regfile.sv
// Register file, 32 x 32 bits with x0 fixed at zero and write-through reads
`timescale 1ns/1ps

module regfile (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  pipe_pkg::commit_t  write_i,
    input  pipe_pkg::reg_idx_t rs1_i,
    input  pipe_pkg::reg_idx_t rs2_i,
    output pipe_pkg::xlen_t    rs1_data_o,
    output pipe_pkg::xlen_t    rs2_data_o
);
    import pipe_pkg::*;

    xlen_t regs_q [32];
    logic  wr_en;

    // x0 is never written
    assign wr_en = write_i.valid && write_i.we && (write_i.rd != '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[write_i.rd] <= write_i.data;
        end
    end

    // Same-cycle write is visible on the read ports
    assign rs1_data_o = (wr_en && write_i.rd == rs1_i) ? write_i.data : regs_q[rs1_i];
    assign rs2_data_o = (wr_en && write_i.rd == rs2_i) ? write_i.data : regs_q[rs2_i];

endmodule

//--- logic/exe_stage.sv
// Execute stage: forwarding from writeback, ALU and branch resolution
`timescale 1ns/1ps

module exe_stage (
    input  pipe_pkg::rr_exe_t   from_rr_i,
    input  pipe_pkg::commit_t   from_wb_i,
    output pipe_pkg::commit_t   to_wb_o,
    output pipe_pkg::redirect_t redirect_o
);
    import pipe_pkg::*;

    id_rr_t instr;
    xlen_t  op_a;
    xlen_t  op_b;
    xlen_t  rs2_val;
    xlen_t  result;
    logic   taken;

    // Pick the writeback value when it targets this source register
    function automatic xlen_t forward(input reg_idx_t src, input xlen_t rf_data,
                                      input commit_t wb);
        xlen_t val;
        val = rf_data;
        if (wb.valid && wb.we && (wb.rd != '0) && (wb.rd == src)) begin
            val = wb.data;
        end
        return val;
    endfunction

    assign instr   = from_rr_i.instr;
    assign op_a    = forward(instr.rs1, from_rr_i.data_rs1, from_wb_i);
    assign rs2_val = forward(instr.rs2, from_rr_i.data_rs2, from_wb_i);
    assign op_b    = instr.use_imm ? instr.imm : rs2_val;

    always_comb begin
        case (instr.alu_op)
            ALU_ADD:      result = op_a + op_b;
            ALU_SUB:      result = op_a - op_b;
            ALU_AND:      result = op_a & op_b;
            ALU_OR:       result = op_a | op_b;
            ALU_XOR:      result = op_a ^ op_b;
            ALU_PASS_IMM: result = instr.imm;
            default:      result = '0;
        endcase
    end

    // Branches compare the two register operands
    always_comb begin
        case (instr.branch_op)
            BR_EQ:   taken = instr.valid && (op_a == rs2_val);
            BR_NE:   taken = instr.valid && (op_a != rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o.valid  = taken;
    assign redirect_o.target = instr.pc + instr.imm;

    always_comb begin
        to_wb_o.valid = instr.valid;
        to_wb_o.pc    = instr.pc;
        to_wb_o.we    = instr.we;
        to_wb_o.rd    = instr.rd;
        // No data for instructions without a register write
        to_wb_o.data  = instr.we ? result : '0;
    end

endmodule

//--- logic/datapath.sv
// Five-stage pipeline top: stage registers, flush on redirect and commit port
`timescale 1ns/1ps

module datapath #(
    parameter pipe_pkg::xlen_t RESET_PC = '0
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  pipe_pkg::icache_resp_t icache_resp_i,
    output pipe_pkg::icache_req_t  icache_req_o,
    output pipe_pkg::commit_t      commit_o
);
    import pipe_pkg::*;

    // Stage registers, _d is the next value and _q the registered one
    if_id_t    fetch_out;
    if_id_t    if_id_d;
    if_id_t    if_id_q;
    id_rr_t    decode_out;
    id_rr_t    id_rr_d;
    id_rr_t    id_rr_q;
    rr_exe_t   rr_exe_d;
    rr_exe_t   rr_exe_q;
    commit_t   exe_wb_d;
    commit_t   exe_wb_q;
    redirect_t redirect;
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .icache_resp_i (icache_resp_i),
        .redirect_i    (redirect),
        .icache_req_o  (icache_req_o),
        .fetch_o       (fetch_out)
    );

    decoder u_decoder (
        .fetch_i  (if_id_q),
        .decode_o (decode_out)
    );

    regfile u_regfile (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .write_i    (exe_wb_q),
        .rs1_i      (id_rr_q.rs1),
        .rs2_i      (id_rr_q.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exe_stage u_exe (
        .from_rr_i  (rr_exe_q),
        .from_wb_i  (exe_wb_q),
        .to_wb_o    (exe_wb_d),
        .redirect_o (redirect)
    );

    // A taken branch drops everything younger than execute
    always_comb begin
        if_id_d       = fetch_out;
        if_id_d.valid = fetch_out.valid && !redirect.valid;

        id_rr_d       = decode_out;
        id_rr_d.valid = decode_out.valid && !redirect.valid;

        rr_exe_d.instr       = id_rr_q;
        rr_exe_d.instr.valid = id_rr_q.valid && !redirect.valid;
        rr_exe_d.data_rs1    = rs1_data;
        rr_exe_d.data_rs2    = rs2_data;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            if_id_q  <= '0;
            id_rr_q  <= '0;
            rr_exe_q <= '0;
            exe_wb_q <= '0;
        end else begin
            if_id_q  <= if_id_d;
            id_rr_q  <= id_rr_d;
            rr_exe_q <= rr_exe_d;
            exe_wb_q <= exe_wb_d;
        end
    end

    // Writeback entry retires here
    assign commit_o = exe_wb_q;

endmodule

//--- tests/icache_model.sv
// Instruction memory model that answers each fetch after a random latency of 1 to 4 cycles
`timescale 1ns/1ps

module icache_model (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  pipe_pkg::icache_req_t  req_i,
    output pipe_pkg::icache_resp_t resp_o
);
    import pipe_pkg::*;

    localparam int MEM_WORDS = 64;

    xlen_t mem [MEM_WORDS];

    initial begin
        // Unused words hold unknown opcodes, distinct per address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {8'hee, 8'(i), 16'h007f};
        end
        mem[0]  = 32'h00500093; // addi x1, x0, 5
        mem[1]  = 32'h00308113; // addi x2, x1, 3
        mem[2]  = 32'h123451b7; // lui  x3, 0x12345
        mem[3]  = 32'h00208233; // add  x4, x1, x2
        mem[4]  = 32'h403202b3; // sub  x5, x4, x3
        mem[5]  = 32'h0032f333; // and  x6, x5, x3
        mem[6]  = 32'h001363b3; // or   x7, x6, x1
        mem[7]  = 32'h0053c433; // xor  x8, x7, x5
        mem[8]  = 32'h00708013; // addi x0, x1, 7
        mem[9]  = 32'h001004b3; // add  x9, x0, x1
        mem[10] = 32'h00208463; // beq  x1, x2, +8 (not taken)
        mem[11] = 32'h00209663; // bne  x1, x2, +12 (taken)
        mem[12] = 32'h7ff00513; // addi x10, x0, 0x7ff (wrong path)
        mem[13] = 32'h00100593; // addi x11, x0, 1 (wrong path)
        mem[14] = 32'h00910633; // add  x12, x2, x9
        mem[15] = 32'h00460663; // beq  x12, x4, +12 (taken)
        mem[16] = 32'h00100693; // addi x13, x0, 1 (wrong path)
        mem[17] = 32'h00100713; // addi x14, x0, 1 (wrong path)
        mem[18] = 32'h0000000b; // custom-0 opcode, unknown
        mem[19] = 32'hfff60793; // addi x15, x12, -1
        mem[20] = 32'h40f00833; // sub  x16, x0, x15
        mem[21] = 32'h00000063; // beq  x0, x0, 0 (self loop)
    end

    // Request seen in cycle c is answered in cycle c + latency
    initial begin : respond
        xlen_t addr;
        int    lat;
        resp_o = '0;
        forever begin
            @(negedge clk_i);
            if (rstn_i && req_i.valid) begin
                addr = req_i.addr;
                lat  = 1 + int'($urandom % 4);
                repeat (lat) @(posedge clk_i);
                #1;
                resp_o.valid = 1'b1;
                resp_o.instr = mem[addr[7:2]];
                @(posedge clk_i);
                #1;
                resp_o = '0;
            end
        end
    end

endmodule

//--- tests/datapath_tb.sv
// Pipeline datapath testbench that checks the commit stream and the fetch request timing
`timescale 1ns/1ps

module datapath_tb;
    import pipe_pkg::*;

    localparam int    N_EXP          = 19;
    localparam int    TIMEOUT_CYCLES = N_EXP * 10 + 50;
    localparam xlen_t RESET_PC       = 32'h0;

    typedef struct packed {
        xlen_t    pc;
        logic     we;
        reg_idx_t rd;
        xlen_t    data;
    } exp_commit_t;

    logic         clk;
    logic         rstn;
    icache_req_t  icache_req;
    icache_resp_t icache_resp;
    commit_t      commit;

    exp_commit_t  exp_tbl [N_EXP];
    // Cycle of the latest fetch response, per word address
    int           resp_cycle [64];
    int           commit_idx;
    int           cycle = 0;
    xlen_t        last_req_addr;
    // Cycles since reset release, counting the release cycle as one
    int           run_cycle;
    logic         resp_prev;

    datapath #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .icache_resp_i (icache_resp),
        .icache_req_o  (icache_req),
        .commit_o      (commit)
    );

    icache_model u_icache (
        .clk_i  (clk),
        .rstn_i (rstn),
        .req_i  (icache_req),
        .resp_o (icache_resp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic set_expected(input int idx, input xlen_t pc, input logic we,
                                input reg_idx_t rd, input xlen_t data);
        exp_tbl[idx].pc   = pc;
        exp_tbl[idx].we   = we;
        exp_tbl[idx].rd   = rd;
        exp_tbl[idx].data = data;
    endtask

    // Results worked out by hand from the program in the memory model
    task automatic load_expected();
        set_expected(0,  32'h00, 1'b1, 5'd1,  32'h0000_0005);
        set_expected(1,  32'h04, 1'b1, 5'd2,  32'h0000_0008);
        set_expected(2,  32'h08, 1'b1, 5'd3,  32'h1234_5000);
        set_expected(3,  32'h0c, 1'b1, 5'd4,  32'h0000_000d);
        set_expected(4,  32'h10, 1'b1, 5'd5,  32'hedcb_b00d);
        set_expected(5,  32'h14, 1'b1, 5'd6,  32'h0000_1000);
        set_expected(6,  32'h18, 1'b1, 5'd7,  32'h0000_1005);
        set_expected(7,  32'h1c, 1'b1, 5'd8,  32'hedcb_a008);
        set_expected(8,  32'h20, 1'b1, 5'd0,  32'h0000_000c);
        set_expected(9,  32'h24, 1'b1, 5'd9,  32'h0000_0005);
        set_expected(10, 32'h28, 1'b0, 5'd0,  32'h0);
        set_expected(11, 32'h2c, 1'b0, 5'd0,  32'h0);
        set_expected(12, 32'h38, 1'b1, 5'd12, 32'h0000_000d);
        set_expected(13, 32'h3c, 1'b0, 5'd0,  32'h0);
        set_expected(14, 32'h48, 1'b0, 5'd0,  32'h0);
        set_expected(15, 32'h4c, 1'b1, 5'd15, 32'h0000_000c);
        set_expected(16, 32'h50, 1'b1, 5'd16, 32'hffff_fff4);
        set_expected(17, 32'h54, 1'b0, 5'd0,  32'h0);
        set_expected(18, 32'h54, 1'b0, 5'd0,  32'h0);
    endtask

    // rd and data only carry meaning for a register write
    task automatic check_commit(input exp_commit_t exp);
        int lat;
        lat = cycle - resp_cycle[commit.pc[7:2]];
        assert (commit.pc == exp.pc)
            else fail_run($sformatf("ERR commit_o.pc got %h expected %h", commit.pc, exp.pc));
        assert (commit.we == exp.we)
            else fail_run($sformatf("ERR commit_o.we got %h expected %h", commit.we, exp.we));
        assert (!exp.we || commit.rd == exp.rd)
            else fail_run($sformatf("ERR commit_o.rd got %h expected %h", commit.rd, exp.rd));
        assert (!exp.we || commit.data == exp.data)
            else fail_run($sformatf("ERR commit_o.data got %h expected %h",
                                    commit.data, exp.data));
        assert (lat == 4)
            else fail_run($sformatf("Commit for pc %h came %0d cycles after its fetch, not 4",
                                    commit.pc, lat));
    endtask

    // One request per accepted response, the first one in the cycle after reset release
    task automatic check_request();
        logic exp_valid;
        exp_valid = (run_cycle == 2) || resp_prev;
        assert (icache_req.valid == exp_valid)
            else fail_run($sformatf("ERR icache_req_o.valid got %h expected %h",
                                    icache_req.valid, exp_valid));
        if (run_cycle == 2) begin
            assert (icache_req.addr == RESET_PC)
                else fail_run($sformatf("ERR icache_req_o.addr got %h expected %h",
                                        icache_req.addr, RESET_PC));
        end
    endtask

    // Fetch, response and commit monitor at the falling edge
    always @(negedge clk) begin
        if (!rstn) begin
            assert (!icache_req.valid) else fail_run("Fetch request issued during reset");
            assert (!commit.valid) else fail_run("Commit seen during reset");
        end else begin
            run_cycle = run_cycle + 1;
            check_request();
            if (icache_req.valid) begin
                last_req_addr = icache_req.addr;
            end
            if (icache_resp.valid) begin
                resp_cycle[last_req_addr[7:2]] = cycle;
            end
            resp_prev = icache_resp.valid;
            if (commit.valid && commit_idx < N_EXP) begin
                check_commit(exp_tbl[commit_idx]);
                commit_idx = commit_idx + 1;
            end
        end
    end

    initial begin
        void'($urandom(63733));
        rstn          = 1'b0;
        commit_idx    = 0;
        run_cycle     = 0;
        resp_prev     = 1'b0;
        last_req_addr = '0;
        for (int i = 0; i < 64; i++) begin
            resp_cycle[i] = -1;
        end
        load_expected();
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        while (commit_idx < N_EXP && cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (commit_idx == N_EXP) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d commits seen",
                               cycle, commit_idx, N_EXP));
        end
    end

endmodule

//--- filelist.f
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/regfile.sv
logic/exe_stage.sv
logic/datapath.sv
tests/icache_model.sv
tests/datapath_tb.sv

//--- run.sh
#!/bin/sh
# Build the datapath testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module datapath_tb \
    -Mdir "$BUILD_DIR" \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vdatapath_tb"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

exit 0
